//--- Makefile
VERILATOR ?= verilator
TOP       ?= stepper_tb
FILELIST  ?= stepper_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
FAIL_MSG  ?= ** FAIL **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; echo "simulator exit status $$?" >> $(LOG)
	cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q 'exit status 0$$' $(LOG) || { echo "simulation stopped early, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/stepper_ref.svh
`ifndef STEPPER_REF_SVH
`define STEPPER_REF_SVH

// floor of the accumulator in whole steps
function automatic longint step_index(input longint acc);
    return acc >>> stepper_pkg::STEP_BIT;
endfunction

// one add per edge, the signed step count is the change of the step index
function automatic int integrate_steps(inout longint acc, input int speed, input int edges);
    longint first_idx;
    first_idx = step_index(acc);
    acc = acc + longint'(speed) * longint'(edges);
    return int'(step_index(acc) - first_idx);
endfunction

function automatic int step_edges(input int steps);
    return (steps < 0) ? -steps : steps;
endfunction

function automatic logic signed [stepper_pkg::X_BITS-1:0] moved_pos(
    input logic signed [stepper_pkg::X_BITS-1:0] pos,
    input int                                    steps
);
    int sum;
    sum = int'(pos) + steps;
    return sum[stepper_pkg::X_BITS-1:0];    // counter wraps
endfunction

function automatic logic follows_channel(input stepper_pkg::motor_cfg_t cfg, input int ch);
    return cfg.step_en && int'(cfg.chan_sel) == ch;
endfunction

// dir pin of an idle axis
function automatic logic dir_pin(input logic neg, input stepper_pkg::motor_cfg_t cfg);
    return neg ^ cfg.invert_dir;
endfunction

// cycles from an accepted strobe until the axis takes the next one
function automatic int pulse_frame(input stepper_pkg::pulse_timing_t t);
    return int'(t.pre_n) + int'(t.pulse_n) + int'(t.post_n) + 1;
endfunction

`endif

//--- dv/stepper_tb.sv
`timescale 1ns/10ps

module stepper_tb;

    localparam int SEED        = 66871;
    localparam int MAX_EDGES   = 400;
    localparam int IDLE_LIMIT  = 100;
    localparam int NUM_RUNS    = 12;    // motion runs over all tests
    localparam int CYCLE_LIMIT = NUM_RUNS * (MAX_EDGES + IDLE_LIMIT + 40) + 200;

    logic                                  clk = 1'b0;
    logic                                  rst;
    stepper_pkg::reg_write_t               host_wr;
    stepper_pkg::motor_pins_t              motor_pins [stepper_pkg::NUM_MOTORS];
    logic signed [stepper_pkg::X_BITS-1:0] motor_pos [stepper_pkg::NUM_MOTORS];

    longint                                acc_model [stepper_pkg::NUM_CHANNELS];
    stepper_pkg::motor_cfg_t               cfg_model [stepper_pkg::NUM_MOTORS];
    stepper_pkg::pulse_timing_t            timing_model;
    logic                                  dir_model [stepper_pkg::NUM_MOTORS];
    logic signed [stepper_pkg::X_BITS-1:0] exp_pos [stepper_pkg::NUM_MOTORS];
    int                                    exp_rise [stepper_pkg::NUM_MOTORS];
    int                                    rise_cnt [stepper_pkg::NUM_MOTORS];
    int                                    high_len [stepper_pkg::NUM_MOTORS];
    logic                                  step_q [stepper_pkg::NUM_MOTORS];
    string                                 test_name;
    int                                    errors, err_mark, tests_run, tests_failed, cycles;
    logic                                  cmp_req, cmp_ack;

    `include "stepper_ref.svh"

    stepper_top i_stepper_top (
        .clk        (clk),
        .rst        (rst),
        .host_wr    (host_wr),
        .motor_pins (motor_pins),
        .motor_pos  (motor_pos)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles == CYCLE_LIMIT) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic report_mismatch(input string what, input int m, input int expected,
                                   input int actual);
        $display("ERR %s: motor %0d %s expected %0d, actual %0d",
                 test_name, m, what, expected, actual);
        errors++;
    endtask

    // step edge counter and high width monitor
    always @(negedge clk) begin
        if (!rst) begin
            for (int m = 0; m < stepper_pkg::NUM_MOTORS; m++) begin
                if (motor_pins[m].step) begin
                    if (!step_q[m]) rise_cnt[m]++;
                    high_len[m]++;
                end else if (step_q[m]) begin
                    assert (high_len[m] == int'(timing_model.pulse_n))
                        else report_mismatch("pulse width", m, timing_model.pulse_n, high_len[m]);
                    high_len[m] = 0;
                end
                step_q[m] = motor_pins[m].step;
            end
        end
    end

    initial begin
        cmp_ack = 1'b0;
        forever begin
            wait (cmp_req === 1'b1);
            for (int m = 0; m < stepper_pkg::NUM_MOTORS; m++) begin
                assert (motor_pos[m] == exp_pos[m])
                    else report_mismatch("position", m, exp_pos[m], motor_pos[m]);
                assert (rise_cnt[m] == exp_rise[m])
                    else report_mismatch("step edges", m, exp_rise[m], rise_cnt[m]);
                assert (motor_pins[m].dir == dir_pin(dir_model[m], cfg_model[m]))
                    else report_mismatch("dir pin", m, dir_pin(dir_model[m], cfg_model[m]),
                                         motor_pins[m].dir);
                assert (motor_pins[m].enable == cfg_model[m].enable)
                    else report_mismatch("enable pin", m, cfg_model[m].enable,
                                         motor_pins[m].enable);
                assert (motor_pins[m].step == 1'b0)
                    else report_mismatch("idle step pin", m, 0, motor_pins[m].step);
            end
            cmp_ack = 1'b1;
            wait (cmp_req === 1'b0);
            cmp_ack = 1'b0;
        end
    end

    // called on a falling edge, the write lands on the next rising edge
    task automatic write_reg(input int addr, input logic [31:0] data);
        host_wr.valid = 1'b1;
        host_wr.addr  = addr[3:0];
        host_wr.data  = data;
        @(negedge clk);
        host_wr.valid = 1'b0;
    endtask

    task automatic set_cfg(input int m, input int chan, input int step_en, input int invert,
                           input int enable);
        stepper_pkg::motor_cfg_t c;
        c            = '0;
        c.chan_sel   = chan[stepper_pkg::SEL_BITS-1:0];
        c.step_en    = step_en != 0;
        c.invert_dir = invert != 0;
        c.enable     = enable != 0;
        write_reg(stepper_pkg::ADDR_CFG_BASE + m, 32'(c));
        cfg_model[m] = c;
    endtask

    task automatic set_timing(input int pre_n, input int pulse_n, input int post_n);
        write_reg(stepper_pkg::ADDR_PRE, pre_n);
        write_reg(stepper_pkg::ADDR_PULSE, pulse_n);
        write_reg(stepper_pkg::ADDR_POST, post_n);
        timing_model = '{pre_n: pre_n[7:0], pulse_n: pulse_n[7:0], post_n: post_n[7:0]};
    endtask

    task automatic preset_pos(input int m, input int val);
        write_reg(stepper_pkg::ADDR_PRESET_BASE + m, val);
        exp_pos[m] = val[stepper_pkg::X_BITS-1:0];
    endtask

    task automatic run_motion(input int ch, input int speed, input int edges);
        int steps;
        int quiet;
        int waited;
        write_reg(stepper_pkg::ADDR_SPEED_BASE + ch, speed);
        repeat (edges - 1) @(negedge clk);
        write_reg(stepper_pkg::ADDR_SPEED_BASE + ch, 0);
        steps = integrate_steps(acc_model[ch], speed, edges);
        for (int m = 0; m < stepper_pkg::NUM_MOTORS; m++) begin
            if (follows_channel(cfg_model[m], ch)) begin
                exp_pos[m] = moved_pos(exp_pos[m], steps);
                exp_rise[m] += step_edges(steps);
                if (steps != 0) dir_model[m] = speed < 0;
            end
        end
        quiet  = 0;
        waited = 0;
        // idle once no step pin went high for longer than a pulse frame
        while (quiet < pulse_frame(timing_model) + 2 && waited < IDLE_LIMIT) begin
            @(negedge clk);
            waited++;
            quiet++;
            for (int m = 0; m < stepper_pkg::NUM_MOTORS; m++) begin
                if (motor_pins[m].step) quiet = 0;
            end
        end
        if (quiet < pulse_frame(timing_model) + 2) begin
            $display("test %s: axes still pulsing after %0d cycles", test_name, waited);
            errors++;
        end
    endtask

    function automatic int rand_speed(input int neg);
        int mag;
        mag = $urandom_range(1500, 7000);    // below one step per pulse frame
        return (neg != 0) ? -mag : mag;
    endfunction

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic finish_test();
        cmp_req = 1'b1;
        wait (cmp_ack === 1'b1);
        cmp_req = 1'b0;
        wait (cmp_ack === 1'b0);
        tests_run++;
        if (errors != err_mark) begin
            tests_failed++;
            $display("test %s: failed, %0d errors", test_name, errors - err_mark);
        end else begin
            $display("test %s: ok", test_name);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        host_wr      = '0;
        cmp_req      = 1'b0;
        timing_model = '0;
        acc_model    = '{default: 0};
        for (int m = 0; m < stepper_pkg::NUM_MOTORS; m++) begin
            cfg_model[m] = '0;
            dir_model[m] = 1'b0;
            exp_pos[m]   = '0;
            step_q[m]    = 1'b0;
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        begin_test("reset_values");
        finish_test();

        set_timing(2, 3, 2);
        begin_test("positive_speed");
        set_cfg(0, 0, 1, 0, 1);
        run_motion(0, rand_speed(0), $urandom_range(150, MAX_EDGES));
        finish_test();

        begin_test("negative_speed");
        set_cfg(1, 0, 1, 1, 1);    // inverted, counts down with dir low
        run_motion(0, rand_speed(1), $urandom_range(150, MAX_EDGES));
        finish_test();

        begin_test("shared_channel");
        set_cfg(0, 2, 1, 0, 1);
        set_cfg(1, 2, 1, 1, 1);
        set_cfg(2, 2, 1, 0, 0);
        set_cfg(3, 2, 0, 0, 1);
        run_motion(2, rand_speed(0), $urandom_range(150, MAX_EDGES));
        run_motion(2, rand_speed(1), $urandom_range(150, MAX_EDGES));
        finish_test();

        begin_test("pulse_timing");
        set_timing(1, 5, 1);
        run_motion(2, rand_speed($urandom_range(0, 1)), $urandom_range(150, MAX_EDGES));
        finish_test();

        begin_test("preset");
        preset_pos(0, int'($urandom_range(0, 20000)) - 10000);
        preset_pos(2, int'($urandom_range(0, 20000)) - 10000);
        run_motion(2, rand_speed($urandom_range(0, 1)), $urandom_range(150, MAX_EDGES));
        finish_test();

        for (int t = 0; t < 6; t++) begin
            begin_test($sformatf("random_%0d", t));
            for (int m = 0; m < stepper_pkg::NUM_MOTORS; m++) begin
                set_cfg(m, $urandom_range(0, stepper_pkg::NUM_CHANNELS - 1),
                        $urandom_range(0, 1), $urandom_range(0, 1), $urandom_range(0, 1));
            end
            run_motion($urandom_range(0, stepper_pkg::NUM_CHANNELS - 1),
                       rand_speed($urandom_range(0, 1)), $urandom_range(150, MAX_EDGES));
            finish_test();
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- source/motor_axis.sv
`timescale 1ns/10ps

module motor_axis (
    input  logic                                  clk,
    input  logic                                  rst,
    input  stepper_pkg::step_strobe_t             strobes [stepper_pkg::NUM_CHANNELS],
    input  stepper_pkg::motor_cfg_t               cfg,
    input  stepper_pkg::pulse_timing_t            timing,
    input  logic                                  preset_stb,
    input  logic signed [stepper_pkg::X_BITS-1:0] preset_val,
    output stepper_pkg::motor_pins_t              pins,
    output logic signed [stepper_pkg::X_BITS-1:0] pos
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PRE,
        ST_PULSE,
        ST_POST
    } shaper_state_t;

    shaper_state_t                       state;
    logic [stepper_pkg::TIMING_BITS-1:0] cnt;    // cycles left in phase, minus one
    stepper_pkg::step_strobe_t           sel;
    logic                                stb;
    logic                                dir_q;
    logic                                dir_raw;

    assign sel = strobes[cfg.chan_sel];
    assign stb = sel.step && cfg.step_en;

    always_ff @(posedge clk) begin
        if (rst) begin
            pos <= '0;
        end else if (preset_stb) begin
            pos <= preset_val;    // preset wins over a step
        end else if (stb) begin
            pos <= sel.dir ? pos - 1'b1 : pos + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) dir_q <= 1'b0;
        else if (stb) dir_q <= sel.dir;
    end

    // new direction shows on the strobe cycle, held after
    assign dir_raw = stb ? sel.dir : dir_q;

    // pre / pulse / post shaper, a pulse_n of zero wraps to 256 cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (stb) begin
                        if (timing.pre_n != '0) begin
                            state <= ST_PRE;
                            cnt   <= timing.pre_n - 1'b1;
                        end else begin
                            state <= ST_PULSE;
                            cnt   <= timing.pulse_n - 1'b1;
                        end
                    end
                end
                ST_PRE: begin
                    if (cnt == '0) begin
                        state <= ST_PULSE;
                        cnt   <= timing.pulse_n - 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_PULSE: begin
                    if (cnt == '0) begin
                        state <= (timing.post_n != '0) ? ST_POST : ST_IDLE;
                        cnt   <= timing.post_n - 1'b1;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin    // ST_POST
                    if (cnt == '0) state <= ST_IDLE;
                    else cnt <= cnt - 1'b1;
                end
            endcase
        end
    end

    assign pins = '{
        step:   state == ST_PULSE,
        dir:    dir_raw ^ cfg.invert_dir,
        enable: cfg.enable
    };

    // step rate from the integrator must fit the pulse timing
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        stb |-> state == ST_IDLE);

endmodule

//--- source/motor_regs.sv
`timescale 1ns/10ps

module motor_regs (
    input  logic                                    clk,
    input  logic                                    rst,
    input  stepper_pkg::reg_write_t                 host_wr,
    output logic signed [stepper_pkg::SPEED_BITS-1:0] speeds [stepper_pkg::NUM_CHANNELS],
    output stepper_pkg::motor_cfg_t                 cfgs [stepper_pkg::NUM_MOTORS],
    output stepper_pkg::pulse_timing_t              timing,
    output logic [stepper_pkg::NUM_MOTORS-1:0]      preset_stb,
    output logic signed [stepper_pkg::X_BITS-1:0]   preset_val
);

    logic [stepper_pkg::NUM_CHANNELS-1:0] speed_hit;
    logic [stepper_pkg::NUM_MOTORS-1:0]   cfg_hit;
    logic [stepper_pkg::NUM_MOTORS-1:0]   preset_hit;
    logic signed [stepper_pkg::SPEED_BITS-1:0] wr_speed;

    assign wr_speed = host_wr.data[stepper_pkg::SPEED_BITS-1:0];

    // address decode
    always_comb begin
        speed_hit  = '0;
        cfg_hit    = '0;
        preset_hit = '0;
        for (int i = 0; i < stepper_pkg::NUM_CHANNELS; i++) begin
            speed_hit[i] = host_wr.valid &&
                           host_wr.addr == 4'(stepper_pkg::ADDR_SPEED_BASE + i);
        end
        for (int i = 0; i < stepper_pkg::NUM_MOTORS; i++) begin
            cfg_hit[i]    = host_wr.valid &&
                            host_wr.addr == 4'(stepper_pkg::ADDR_CFG_BASE + i);
            preset_hit[i] = host_wr.valid &&
                            host_wr.addr == 4'(stepper_pkg::ADDR_PRESET_BASE + i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            speeds     <= '{default: '0};
            cfgs       <= '{default: '0};
            timing     <= '0;
            preset_stb <= '0;
        end else begin
            for (int i = 0; i < stepper_pkg::NUM_CHANNELS; i++) begin
                if (speed_hit[i]) speeds[i] <= wr_speed;
            end
            for (int i = 0; i < stepper_pkg::NUM_MOTORS; i++) begin
                if (cfg_hit[i])
                    cfgs[i] <= host_wr.data[$bits(stepper_pkg::motor_cfg_t)-1:0];
            end
            if (host_wr.valid && host_wr.addr == 4'(stepper_pkg::ADDR_PRE))
                timing.pre_n <= host_wr.data[stepper_pkg::TIMING_BITS-1:0];
            if (host_wr.valid && host_wr.addr == 4'(stepper_pkg::ADDR_PULSE))
                timing.pulse_n <= host_wr.data[stepper_pkg::TIMING_BITS-1:0];
            if (host_wr.valid && host_wr.addr == 4'(stepper_pkg::ADDR_POST))
                timing.post_n <= host_wr.data[stepper_pkg::TIMING_BITS-1:0];
            preset_stb <= preset_hit;    // one cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (|preset_hit) preset_val <= host_wr.data[stepper_pkg::X_BITS-1:0];
    end

    // keeps the integrators at one step strobe per cycle at most
    a_speed_range: assert property (@(posedge clk) disable iff (rst)
        |speed_hit |-> (wr_speed < 2**stepper_pkg::STEP_BIT) &&
                       (wr_speed > -(2**stepper_pkg::STEP_BIT)));

endmodule

//--- source/speed_integrator.sv
`timescale 1ns/10ps

module speed_integrator (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic signed [stepper_pkg::SPEED_BITS-1:0] speed,
    output stepper_pkg::step_strobe_t                 strobe
);

    logic signed [stepper_pkg::SPEED_BITS-1:0] acc;
    logic signed [stepper_pkg::SPEED_BITS-1:0] acc_next;
    logic                                      step_flip;

    assign acc_next = acc + speed;

    // a crossing of a step boundary toggles the step bit
    assign step_flip = acc_next[stepper_pkg::STEP_BIT] != acc[stepper_pkg::STEP_BIT];

    always_ff @(posedge clk) begin
        if (rst) begin
            acc    <= '0;
            strobe <= '0;
        end else begin
            acc         <= acc_next;    // wraps freely
            strobe.step <= step_flip;
            strobe.dir  <= speed[stepper_pkg::SPEED_BITS-1];
        end
    end

    // the host keeps the step rate low enough for the axes to follow
    a_no_back_to_back: assert property (@(posedge clk) disable iff (rst)
        strobe.step |=> !strobe.step);

endmodule

//--- source/stepper_pkg.sv
package stepper_pkg;

    localparam int NUM_CHANNELS = 4;
    localparam int NUM_MOTORS   = 4;
    localparam int SPEED_BITS   = 24;    // signed speed and accumulator
    localparam int STEP_BIT     = 16;
    localparam int X_BITS       = 16;
    localparam int TIMING_BITS  = 8;

    // channel select width, at least one bit
    localparam int SEL_BITS = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    // register map
    localparam int ADDR_SPEED_BASE  = 0;
    localparam int ADDR_CFG_BASE    = 4;
    localparam int ADDR_PRE         = 8;
    localparam int ADDR_PULSE       = 9;
    localparam int ADDR_POST        = 10;
    localparam int ADDR_PRESET_BASE = 12;

    typedef struct packed {
        logic        valid;
        logic [3:0]  addr;
        logic [31:0] data;
    } reg_write_t;

    // cfg word, lsb first: chan_sel, step_en, invert_dir, enable
    typedef struct packed {
        logic                enable;
        logic                invert_dir;
        logic                step_en;
        logic [SEL_BITS-1:0] chan_sel;
    } motor_cfg_t;

    typedef struct packed {
        logic step;
        logic dir;    // 1 = negative
    } step_strobe_t;

    typedef struct packed {
        logic [TIMING_BITS-1:0] pre_n;
        logic [TIMING_BITS-1:0] pulse_n;
        logic [TIMING_BITS-1:0] post_n;
    } pulse_timing_t;

    typedef struct packed {
        logic step;
        logic dir;
        logic enable;
    } motor_pins_t;

endpackage

//--- source/stepper_top.sv
`timescale 1ns/10ps

module stepper_top (
    input  logic                                  clk,
    input  logic                                  rst,
    input  stepper_pkg::reg_write_t               host_wr,
    output stepper_pkg::motor_pins_t              motor_pins [stepper_pkg::NUM_MOTORS],
    output logic signed [stepper_pkg::X_BITS-1:0] motor_pos [stepper_pkg::NUM_MOTORS]
);

    logic signed [stepper_pkg::SPEED_BITS-1:0] speeds [stepper_pkg::NUM_CHANNELS];
    stepper_pkg::motor_cfg_t                   cfgs [stepper_pkg::NUM_MOTORS];
    stepper_pkg::pulse_timing_t                timing;
    logic [stepper_pkg::NUM_MOTORS-1:0]        preset_stb;
    logic signed [stepper_pkg::X_BITS-1:0]     preset_val;
    stepper_pkg::step_strobe_t                 strobes [stepper_pkg::NUM_CHANNELS];

    motor_regs i_motor_regs (
        .clk        (clk),
        .rst        (rst),
        .host_wr    (host_wr),
        .speeds     (speeds),
        .cfgs       (cfgs),
        .timing     (timing),
        .preset_stb (preset_stb),
        .preset_val (preset_val)
    );

    // one integrator per speed channel
    for (genvar ch = 0; ch < stepper_pkg::NUM_CHANNELS; ch++) begin : g_channel
        speed_integrator i_speed_integrator (
            .clk    (clk),
            .rst    (rst),
            .speed  (speeds[ch]),
            .strobe (strobes[ch])
        );
    end

    // every axis sees all channels
    for (genvar m = 0; m < stepper_pkg::NUM_MOTORS; m++) begin : g_motor
        motor_axis i_motor_axis (
            .clk        (clk),
            .rst        (rst),
            .strobes    (strobes),
            .cfg        (cfgs[m]),
            .timing     (timing),
            .preset_stb (preset_stb[m]),
            .preset_val (preset_val),
            .pins       (motor_pins[m]),
            .pos        (motor_pos[m])
        );
    end

endmodule

//--- stepper_top.f
+incdir+dv
source/stepper_pkg.sv
source/speed_integrator.sv
source/motor_axis.sv
source/motor_regs.sv
source/stepper_top.sv
dv/stepper_tb.sv
